//--- verilog/dcache_pkg.sv
// word and address types, address field widths, controller and memory-op enums, hit count address
package dcache_pkg;

  // data word, also used for byte addresses
  typedef logic [31:0] word_t;

  // block geometry
  localparam int WORDS_PER_BLK = 2;
  localparam int WSEL_W        = $clog2(WORDS_PER_BLK); // word select inside a block
  localparam int BLKOFF_W      = WSEL_W + 2;            // word select plus byte bits

  // hit count lands here once the flush is done
  localparam word_t HIT_CNT_ADDR = 32'h0000_3100;

  // controller states
  typedef enum logic [2:0] {
    IDLE,       // lookup, hits answered here
    WB,         // dirty victim going out
    FILL,       // block coming in
    FLUSH_SCAN, // look at one frame of the walk
    FLUSH_WB,   // dirty frame going out during flush
    HIT_STORE,  // single word write of the hit count
    HALTED      // flushed, parked until reset
  } ctrl_state_t;

  // command from controller to memory port
  typedef enum logic [1:0] {
    MEM_NONE, // bus idle
    MEM_WB,   // write words to memory
    MEM_FILL  // read words from memory
  } mem_op_t;

endpackage

//--- verilog/dcache_store.sv
// frame storage for the two-way data cache: tag, valid, dirty, lru and data arrays with lookup
`timescale 1ns/1ps

module dcache_store #(
  parameter  int NSETS = 8,
  localparam int IDX_W = $clog2(NSETS),
  localparam int TAG_W = 32 - IDX_W - dcache_pkg::BLKOFF_W
) (
  input  logic                          CLK,
  input  logic                          nRST,
  // lookup side
  input  dcache_pkg::word_t             addr,
  input  logic                          wr_hit_we,
  input  dcache_pkg::word_t             wdata,
  // fill side
  input  logic                          fill_we,
  input  logic [dcache_pkg::WSEL_W-1:0] fill_word,
  input  dcache_pkg::word_t             fill_data,
  input  logic                          fill_last,
  input  logic                          fill_way,
  // frame select for write-back and flush
  input  logic [IDX_W-1:0]              sel_set,
  input  logic                          sel_way,
  input  logic                          clean_we,
  output logic                          hit,
  output logic                          hit_way,
  output dcache_pkg::word_t             rdata,
  output logic                          victim_way,
  output logic                          victim_dirty,
  output logic [TAG_W-1:0]              sel_tag,
  output logic                          sel_dirty,
  output dcache_pkg::word_t             sel_word0,
  output dcache_pkg::word_t             sel_word1
);
  import dcache_pkg::*;

  // control bits per set, [way]
  logic [NSETS-1:0][1:0] valid_q;
  logic [NSETS-1:0][1:0] dirty_q;
  logic [NSETS-1:0]      lru_q;     // way to evict next

  // payload arrays
  logic [TAG_W-1:0] tag_mem  [NSETS][2];
  word_t            data_mem [NSETS][2][WORDS_PER_BLK];

  // request address fields
  logic [IDX_W-1:0]  idx;
  logic [TAG_W-1:0]  tag;
  logic [WSEL_W-1:0] wsel;
  logic              match0;
  logic              match1;

  assign idx  = addr[BLKOFF_W +: IDX_W];
  assign tag  = addr[31 -: TAG_W];
  assign wsel = addr[2 +: WSEL_W];

  // tag compare on both ways of the set
  assign match0 = valid_q[idx][0] && (tag_mem[idx][0] == tag);
  assign match1 = valid_q[idx][1] && (tag_mem[idx][1] == tag);

  assign hit     = match0 || match1;
  assign hit_way = match1;                        // ways never match together
  assign rdata   = data_mem[idx][hit_way][wsel];

  // empty way first, else the lru way
  always_comb begin
    if (!valid_q[idx][0]) begin
      victim_way = 1'b0;
    end else if (!valid_q[idx][1]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[idx];
    end
  end

  assign victim_dirty = dirty_q[idx][victim_way]; // dirty only ever set on a valid frame

  // frame picked by the controller, write-back and flush walk
  assign sel_tag   = tag_mem[sel_set][sel_way];
  assign sel_dirty = dirty_q[sel_set][sel_way];
  assign sel_word0 = data_mem[sel_set][sel_way][0];
  assign sel_word1 = data_mem[sel_set][sel_way][1];

  // valid, dirty and lru
  always_ff @(posedge CLK) begin
    if (!nRST) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;                       // way 0 goes first
    end else begin
      if (fill_we && fill_last) begin
        valid_q[idx][fill_way] <= 1'b1;
        dirty_q[idx][fill_way] <= 1'b0;    // fresh copy of memory
        lru_q[idx]             <= ~fill_way;
      end else begin
        if (hit) begin
          lru_q[idx] <= ~hit_way;          // touched way is now newest
        end
        if (wr_hit_we) begin
          dirty_q[idx][hit_way] <= 1'b1;
        end
      end
      // frame just written back
      if (clean_we) begin
        dirty_q[sel_set][sel_way] <= 1'b0;
      end
    end
  end

  // tags and data
  always_ff @(posedge CLK) begin
    if (fill_we) begin
      data_mem[idx][fill_way][fill_word] <= fill_data;
    end
    if (fill_we && fill_last) begin
      tag_mem[idx][fill_way] <= tag;       // tag goes in with the last word
    end
    if (wr_hit_we) begin
      data_mem[idx][hit_way][wsel] <= wdata;
    end
  end

endmodule

//--- verilog/dcache_ctrl.sv
// controller FSM for the data cache: hits, misses, flush walk, hit count store and hit counter
`timescale 1ns/1ps

module dcache_ctrl #(
  parameter  int NSETS = 8,
  localparam int IDX_W = $clog2(NSETS),
  localparam int TAG_W = 32 - IDX_W - dcache_pkg::BLKOFF_W
) (
  input  logic                CLK,
  input  logic                nRST,
  // processor side
  input  logic                dmemren,
  input  logic                dmemwen,
  input  dcache_pkg::word_t   dmemaddr,
  input  logic                halt,
  // from the store
  input  logic                hit,
  input  logic                victim_way,
  input  logic                victim_dirty,
  input  logic [TAG_W-1:0]    sel_tag,
  input  logic                sel_dirty,
  // from the memory port
  input  logic                word_done,
  input  logic                blk_done,
  output logic                dhit,
  output logic                wr_hit_we,
  output logic                fill_way,
  output logic                fill_last,
  output logic [IDX_W-1:0]    sel_set,
  output logic                sel_way,
  output logic                clean_we,
  output dcache_pkg::mem_op_t mem_op,
  output dcache_pkg::word_t   mem_base,
  output dcache_pkg::word_t   hit_count,
  output logic                flushed
);
  import dcache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;

  logic             victim_q;     // way chosen at the miss
  logic [IDX_W:0]   walk_q;       // flush walk, {set, way}
  logic             just_filled;  // next dhit is the replayed access
  logic             req;
  logic             in_flush;
  logic             walk_last;
  logic             walk_step;
  logic [IDX_W-1:0] req_idx;

  assign req       = dmemren || dmemwen;
  assign req_idx   = dmemaddr[BLKOFF_W +: IDX_W];
  assign in_flush  = (state == FLUSH_SCAN) || (state == FLUSH_WB);
  assign walk_last = &walk_q;     // last way of the last set

  // hits only answered in IDLE, halt wins
  assign dhit      = (state == IDLE) && !halt && req && hit;
  assign wr_hit_we = dhit && dmemwen;

  // frame selection, walk during flush, else the held miss
  assign sel_set   = in_flush ? walk_q[IDX_W:1] : req_idx;
  assign sel_way   = in_flush ? walk_q[0] : victim_q;

  assign fill_way  = victim_q;
  assign fill_last = (state == FILL) && blk_done;
  assign clean_we  = ((state == WB) || (state == FLUSH_WB)) && blk_done;
  assign flushed   = (state == HALTED);

  // clean frame skipped, dirty one stepped past after its write-back
  assign walk_step = ((state == FLUSH_SCAN) && !sel_dirty) ||
                     ((state == FLUSH_WB) && blk_done);

  always_comb begin
    next_state = state;
    unique case (state)
      IDLE: begin
        if (halt) begin
          next_state = FLUSH_SCAN;
        end else if (req && !hit) begin
          next_state = victim_dirty ? WB : FILL;  // old block out first if dirty
        end
      end
      WB: begin
        if (blk_done) next_state = FILL;
      end
      FILL: begin
        if (blk_done) next_state = IDLE;          // held request hits there
      end
      FLUSH_SCAN: begin
        if (sel_dirty) begin
          next_state = FLUSH_WB;
        end else if (walk_last) begin
          next_state = HIT_STORE;
        end
      end
      FLUSH_WB: begin
        if (blk_done) next_state = walk_last ? HIT_STORE : FLUSH_SCAN;
      end
      HIT_STORE: begin
        if (word_done) next_state = HALTED;       // one word only
      end
      HALTED: next_state = HALTED;                // until reset
      default: next_state = IDLE;
    endcase
  end

  // bus command for the memory port
  always_comb begin
    mem_op   = MEM_NONE;
    mem_base = {dmemaddr[31:BLKOFF_W], {BLKOFF_W{1'b0}}}; // block aligned request
    unique case (state)
      WB, FLUSH_WB: begin
        mem_op   = MEM_WB;
        mem_base = {sel_tag, sel_set, {BLKOFF_W{1'b0}}};  // address of the frame leaving
      end
      FILL: begin
        mem_op = MEM_FILL;
      end
      HIT_STORE: begin
        mem_op   = MEM_WB;
        mem_base = HIT_CNT_ADDR;
      end
      default: mem_op = MEM_NONE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      state       <= IDLE;
      victim_q    <= 1'b0;
      walk_q      <= '0;
      hit_count   <= '0;
      just_filled <= 1'b0;
    end else begin
      state <= next_state;
      if ((state == IDLE) && !halt && req && !hit) begin
        victim_q <= victim_way;   // keep the way for WB and FILL
      end
      if ((state == IDLE) && halt) begin
        walk_q <= '0;             // walk starts at set 0 way 0
      end else if (walk_step) begin
        walk_q <= walk_q + 1'b1;
      end
      // replayed access after a fill is not a hit
      if (dhit) begin
        if (!just_filled) begin
          hit_count <= hit_count + 32'd1;
        end
        just_filled <= 1'b0;
      end else if ((state == FILL) && blk_done) begin
        just_filled <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/dcache_mem_port.sv
// memory bus sequencer for the data cache: block write-back, block fill and hit count store
`timescale 1ns/1ps

module dcache_mem_port (
  input  logic                          CLK,
  input  logic                          nRST,
  input  dcache_pkg::mem_op_t           mem_op,
  input  dcache_pkg::word_t             mem_base,
  input  dcache_pkg::word_t             sel_word0,
  input  dcache_pkg::word_t             sel_word1,
  input  dcache_pkg::word_t             hit_count,
  input  dcache_pkg::word_t             dload,
  input  logic                          dwait,
  output logic                          dren,
  output logic                          dwen,
  output dcache_pkg::word_t             daddr,
  output dcache_pkg::word_t             dstore,
  output logic                          word_done,
  output logic                          blk_done,
  output logic                          fill_we,
  output logic [dcache_pkg::WSEL_W-1:0] fill_word,
  output dcache_pkg::word_t             fill_data
);
  import dcache_pkg::*;

  logic [WSEL_W-1:0] word_cnt;  // word of the block on the bus
  logic              is_store;
  logic              accept;
  logic              last;

  // hit count store is a single word write
  assign is_store = (mem_op == MEM_WB) && (mem_base == HIT_CNT_ADDR);

  assign dren = (mem_op == MEM_FILL);
  assign dwen = (mem_op == MEM_WB);

  // held steady by the counter while dwait is high
  assign daddr  = mem_base + (word_t'(word_cnt) << 2);
  assign dstore = is_store ? hit_count :
                  (word_cnt == '0) ? sel_word0 : sel_word1;

  assign accept    = (dren || dwen) && !dwait;
  assign last      = is_store || (word_cnt == WSEL_W'(WORDS_PER_BLK - 1));
  assign word_done = accept;
  assign blk_done  = accept && last;

  // fill words go straight into the store
  assign fill_we   = dren && !dwait;
  assign fill_word = word_cnt;
  assign fill_data = dload;

  always_ff @(posedge CLK) begin
    if (!nRST || (mem_op == MEM_NONE)) begin
      word_cnt <= '0;
    end else if (accept) begin
      word_cnt <= last ? '0 : word_cnt + 1'b1;  // back to 0 for a WB then FILL
    end
  end

endmodule

//--- verilog/dcache.sv
// top level of the two-way write-back data cache: store, controller and memory port
`timescale 1ns/1ps

module dcache #(
  parameter  int NSETS = 8,
  localparam int IDX_W = $clog2(NSETS),
  localparam int TAG_W = 32 - IDX_W - dcache_pkg::BLKOFF_W
) (
  input  logic              CLK,
  input  logic              nRST,
  // processor side
  input  logic              dmemren,
  input  logic              dmemwen,
  input  dcache_pkg::word_t dmemaddr,
  input  dcache_pkg::word_t dmemstore,
  input  logic              halt,
  output logic              dhit,
  output dcache_pkg::word_t dmemload,
  output logic              flushed,
  // memory side
  output logic              dren,
  output logic              dwen,
  output dcache_pkg::word_t daddr,
  output dcache_pkg::word_t dstore,
  input  dcache_pkg::word_t dload,
  input  logic              dwait
);
  import dcache_pkg::*;

  // store to controller
  logic             hit;
  logic             victim_way;
  logic             victim_dirty;
  logic [TAG_W-1:0] sel_tag;
  logic             sel_dirty;
  word_t            sel_word0;
  word_t            sel_word1;
  word_t            rdata;
  // controller to store and port
  logic             wr_hit_we;
  logic             fill_way;
  logic             fill_last;
  logic [IDX_W-1:0] sel_set;
  logic             sel_way;
  logic             clean_we;
  mem_op_t          mem_op;
  word_t            mem_base;
  word_t            hit_count;
  // port back to controller and store
  logic             word_done;
  logic             blk_done;
  logic             fill_we;
  logic [WSEL_W-1:0] fill_word;
  word_t            fill_data;

  assign dmemload = rdata;  // valid while dhit is high

  dcache_store #(.NSETS(NSETS)) i_store (
    .CLK, .nRST,
    .addr (dmemaddr), .wr_hit_we, .wdata (dmemstore),
    .fill_we, .fill_word, .fill_data, .fill_last, .fill_way,
    .sel_set, .sel_way, .clean_we,
    .hit, .hit_way (), .rdata,      // hit way only steers writes inside the store
    .victim_way, .victim_dirty,
    .sel_tag, .sel_dirty, .sel_word0, .sel_word1
  );

  dcache_ctrl #(.NSETS(NSETS)) i_ctrl (
    .CLK, .nRST,
    .dmemren, .dmemwen, .dmemaddr, .halt,
    .hit, .victim_way, .victim_dirty, .sel_tag, .sel_dirty,
    .word_done, .blk_done,
    .dhit, .wr_hit_we, .fill_way, .fill_last,
    .sel_set, .sel_way, .clean_we,
    .mem_op, .mem_base, .hit_count, .flushed
  );

  dcache_mem_port i_mem_port (
    .CLK, .nRST,
    .mem_op, .mem_base, .sel_word0, .sel_word1, .hit_count,
    .dload, .dwait,
    .dren, .dwen, .daddr, .dstore,
    .word_done, .blk_done,
    .fill_we, .fill_word, .fill_data
  );

endmodule

//--- tests/dcache_asserts.sv
// concurrent assertions on the memory bus and the flushed flag, bound to the cache top level
`timescale 1ns/1ps

module dcache_asserts (
  input logic              CLK,
  input logic              nRST,
  input logic              dren,
  input logic              dwen,
  input logic              dwait,
  input logic              flushed,
  input dcache_pkg::word_t daddr,
  input dcache_pkg::word_t dstore
);

  int fail_count = 0;  // summed into the run result

  // one bus direction at a time
  one_direction: assert property (@(posedge CLK) disable iff (!nRST) !(dren && dwen))
    else begin
      fail_count++;
      $error("dren and dwen high in the same cycle");
    end

  // request frozen under back-pressure
  hold_under_wait: assert property (@(posedge CLK) disable iff (!nRST)
    (dren || dwen) && dwait |=> $stable(daddr) && $stable(dstore) && $stable(dren) && $stable(dwen))
    else begin
      fail_count++;
      $error("bus request changed while dwait was high");
    end

  // flushed sticks until reset
  stays_flushed: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
    else begin
      fail_count++;
      $error("flushed fell without a reset");
    end

endmodule

bind dcache dcache_asserts i_asserts (.*);

//--- tests/dcache_tb.sv
// data cache testbench with clock, reset, memory model, cache model, compare task and tests
`timescale 1ns/1ps

module dcache_tb;
  import dcache_pkg::*;

  localparam int NSETS   = 8;    // dcache default geometry
  localparam int TIMEOUT = 400;  // cycles per wait

  logic  CLK;
  logic  nRST;
  logic  dmemren, dmemwen, halt;
  word_t dmemaddr, dmemstore;
  logic  dhit, flushed;
  word_t dmemload;
  logic  dren, dwen, dwait;
  word_t daddr, dstore, dload;

  word_t mem [word_t];      // what the bus actually wrote
  word_t ref_mem [word_t];  // what the processor expects to read
  word_t bus_log [$];       // accepted word addresses with bit 0 set on writes
  bit    slow;              // every word waits the full 2 cycles
  int    errors, tests, err_at_start, exp_hits;
  string cur_test;

  // 2-way lru model holding the block address of each frame
  word_t m_blk [NSETS][2];
  bit    m_val [NSETS][2];
  bit    m_lru [NSETS];

  dcache i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic word_t fill_pattern(word_t a);
    return (a * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;  // unwritten memory
  endfunction

  function automatic word_t read_mem(word_t a);
    return mem.exists(a) ? mem[a] : fill_pattern(a);
  endfunction

  function automatic word_t expect_word(word_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_pattern(a);
  endfunction

  // returns 1 on a hit and otherwise allocates like a miss
  function automatic bit model_lookup(word_t a);
    word_t blk;
    int    s;
    bit    w;
    blk = a >> 3;
    s   = int'(blk % NSETS);
    for (int i = 0; i < 2; i++) begin
      if (m_val[s][i] && (m_blk[s][i] == blk)) begin
        m_lru[s] = (i == 0);  // other way is now oldest
        return 1'b1;
      end
    end
    w = !m_val[s][0] ? 1'b0 : !m_val[s][1] ? 1'b1 : m_lru[s];
    m_val[s][w] = 1'b1;
    m_blk[s][w] = blk;
    m_lru[s]    = !w;
    return 1'b0;
  endfunction

  // memory model sets dwait and dload after the edge and takes words mid cycle
  initial begin : mem_model
    int wait_left;
    bit fresh;
    wait_left = 0;
    fresh     = 1'b1;
    dwait     = 1'b0;
    dload     = '0;
    forever begin
      @(posedge CLK);
      #1;
      if (nRST && (dren || dwen)) begin
        if (fresh) begin
          wait_left = slow ? 2 : $urandom_range(0, 2);
          fresh     = 1'b0;
        end
        dwait = (wait_left > 0);
        if (wait_left > 0) wait_left--;
        dload = dren ? read_mem(daddr) : '0;
      end else begin
        dwait = 1'b0;
        fresh = 1'b1;
      end
      @(negedge CLK);
      if (nRST && (dren || dwen) && !dwait) begin
        if (dwen) mem[daddr] = dstore;
        bus_log.push_back(daddr | word_t'(dwen));
        fresh = 1'b1;  // next word draws a new wait
      end
    end
  end

  task automatic compare_word(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s did not happen within %0d cycles in %s", what, TIMEOUT, cur_test);
    $display("Test failed");
    $finish;
  endtask

  task automatic start_test(input string name);
    cur_test     = slow ? {name, "_slow"} : name;
    err_at_start = errors;
    tests++;
  endtask

  task automatic end_test();
    $display("%s done, %0d errors", cur_test, errors - err_at_start);
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    #1;
    nRST    = 1'b0;
    halt    = 1'b0;
    dmemren = 1'b0;
    dmemwen = 1'b0;
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    for (int s = 0; s < NSETS; s++) begin
      m_val[s][0] = 1'b0;
      m_val[s][1] = 1'b0;
      m_lru[s]    = 1'b0;
    end
    exp_hits = 0;  // dut counter clears too
  endtask

  // one processor request held until dhit
  task automatic access(input bit wr, input word_t a, input word_t wdata,
                        output word_t rd, output int words);
    int n;
    int log_start;
    bit hit_exp;
    hit_exp   = model_lookup(a);
    log_start = bus_log.size();
    dmemren   = !wr;
    dmemwen   = wr;
    dmemaddr  = a;
    dmemstore = wdata;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
      if (n > TIMEOUT) abort_run($sformatf("dhit for address %h", a));
    end while (!dhit);
    rd    = dmemload;
    words = bus_log.size() - log_start;
    @(posedge CLK);
    #1;
    dmemren = 1'b0;
    dmemwen = 1'b0;
    if (hit_exp) begin
      exp_hits++;
      compare_word($sformatf("bus words on hit %h", a), 0, words);
      compare_word($sformatf("cycles to dhit on hit %h", a), 1, n);  // same cycle answer
    end else begin
      compare_word($sformatf("fill seen on miss %h", a), 1, word_t'(words >= 2));
    end
    if (wr) ref_mem[a] = wdata;
    else compare_word($sformatf("read %h", a), expect_word(a), rd);
  endtask

  task automatic read_miss_then_hits();
    word_t rd;
    int    words;
    start_test("read_miss");
    access(1'b0, 32'h1000, '0, rd, words);  // miss and block fill
    access(1'b0, 32'h1000, '0, rd, words);
    compare_word("bus words on repeat", 0, words);
    access(1'b0, 32'h1004, '0, rd, words);  // second word of the block
    compare_word("bus words on second word", 0, words);
    end_test();
  endtask

  task automatic write_hit_readback();
    word_t rd, old, val;
    int    words;
    start_test("write_hit");
    old = read_mem(32'h1004);
    val = $urandom;
    access(1'b1, 32'h1004, val, rd, words);
    access(1'b0, 32'h1004, '0, rd, words);
    compare_word("readback", val, rd);
    compare_word("memory before eviction", old, read_mem(32'h1004));
    end_test();
  endtask

  task automatic lru_evict_dirty();
    word_t a, b, c, rd, w0, w1;
    int    words, pos;
    start_test("lru_evict");
    a  = 32'h2010;
    b  = a + NSETS * 8;      // same set with the next tag
    c  = a + 2 * NSETS * 8;
    w0 = $urandom;
    w1 = $urandom;
    access(1'b1, a, w0, rd, words);
    access(1'b1, a + 4, w1, rd, words);
    access(1'b0, b, '0, rd, words);  // a is now oldest
    pos = bus_log.size();
    access(1'b0, c, '0, rd, words);  // evicts a
    compare_word("write-back word 0", w0, read_mem(a));
    compare_word("write-back word 1", w1, read_mem(a + 4));
    compare_word("bus words on eviction", 4, words);
    if (words == 4) begin
      compare_word("first bus word", a | 32'd1, bus_log[pos]);
      compare_word("second bus word", (a + 4) | 32'd1, bus_log[pos + 1]);
      compare_word("third bus word", c, bus_log[pos + 2]);
    end
    access(1'b0, b, '0, rd, words);  // b survives the eviction
    compare_word("bus words on newest block", 0, words);
    end_test();
  endtask

  task automatic flush_on_halt();
    word_t a, rd;
    int    words, n;
    start_test("flush");
    repeat (24) begin
      a = 32'h4000 + ($urandom_range(0, 255) << 2);
      access(1'($urandom_range(0, 1)), a, $urandom, rd, words);
    end
    halt = 1'b1;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
      if (n > TIMEOUT) abort_run("flushed");
    end while (!flushed);
    foreach (ref_mem[k]) compare_word($sformatf("memory %h", k), ref_mem[k], read_mem(k));
    compare_word("hit count", exp_hits, read_mem(32'h3100));
    compare_word("last bus word", 32'h3100 | 32'd1, bus_log[$]);  // count goes out last
    end_test();
  endtask

  task automatic rerun_with_max_wait();
    slow = 1'b1;
    apply_reset();
    read_miss_then_hits();
    write_hit_readback();
    lru_evict_dirty();
    flush_on_halt();
    slow = 1'b0;
  endtask

  initial begin
    void'($urandom(92));
    nRST      = 1'b0;
    dmemren   = 1'b0;
    dmemwen   = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    halt      = 1'b0;
    slow      = 1'b0;
    errors    = 0;
    tests     = 0;
    cur_test  = "reset";
    apply_reset();
    read_miss_then_hits();
    write_hit_readback();
    lru_evict_dirty();
    flush_on_halt();
    rerun_with_max_wait();
    if (i_dut.i_asserts.fail_count != 0) begin
      $display("%0d bus assertion failures", i_dut.i_asserts.fail_count);
      errors += i_dut.i_asserts.fail_count;
    end
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- all.f
verilog/dcache_pkg.sv
verilog/dcache_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_mem_port.sv
verilog/dcache.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_store.sv
  - verilog/dcache_ctrl.sv
  - verilog/dcache_mem_port.sv
  - verilog/dcache.sv
  - target: test
    files:
      - tests/dcache_asserts.sv
      - tests/dcache_tb.sv
